// ==== design/rv_id_pkg.sv ====
// RV64I only, no M extension and no system opcodes; opcode constants match inst[6:2]
package rv_id_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [ILEN-1:0] inst_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes, inst[6:2]
  localparam logic [4:0] OPC_LOAD    = 5'b00000;
  localparam logic [4:0] OPC_OP_IMM  = 5'b00100;
  localparam logic [4:0] OPC_AUIPC   = 5'b00101;
  localparam logic [4:0] OPC_OP_IMMW = 5'b00110;
  localparam logic [4:0] OPC_STORE   = 5'b01000;
  localparam logic [4:0] OPC_OP      = 5'b01100;
  localparam logic [4:0] OPC_LUI     = 5'b01101;
  localparam logic [4:0] OPC_OPW     = 5'b01110;
  localparam logic [4:0] OPC_BRANCH  = 5'b11000;
  localparam logic [4:0] OPC_JALR    = 5'b11001;
  localparam logic [4:0] OPC_JAL     = 5'b11011;

  typedef enum logic [3:0] {
    CLS_NONE,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_REGREG,
    CLS_REGIMM,
    CLS_REGREGW,
    CLS_REGIMMW,
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR
  } inst_class_e;

  typedef enum logic [3:0] {
    NOP, ADD, SUB, SLL, SLT, SLTU, XOR, SRL,
    SRA, OR, AND, ADDW, SUBW, SLLW, SRLW, SRAW
  } alu_op_e;

  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_t inst;
  } fetch_t;

  typedef struct packed {
    logic      ena;
    reg_addr_t addr;
  } rd_write_t;

  typedef struct packed {
    rd_write_t wr;
    word_t     data;
  } fwd_t;

  typedef struct packed {
    inst_class_e cls;
    alu_op_e     alu_op;
    logic [2:0]  funct3;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic        rs1_rd;
    logic        rs2_rd;
    rd_write_t   rd;
    word_t       imm;
    logic [11:0] mem_offset;
  } dec_t;

  typedef struct packed {
    logic        valid;
    word_t       pc;
    inst_class_e cls;
    alu_op_e     alu_op;
    logic [2:0]  funct3;
    word_t       op1;
    word_t       op2;
    rd_write_t   rd;
    logic [11:0] mem_offset;
  } id_ex_t;

endpackage

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ps
// invalid fetch decodes as CLS_NONE; LUI/AUIPC imm is the raw U field, unshifted
module rv_decoder import rv_id_pkg::*; (
  input  fetch_t fetch_i,
  output dec_t   dec_o
);

  inst_t       inst;
  logic [4:0]  opc;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  logic        alt;
  logic        f7_zero;
  logic        f7_alt;
  logic        sh6_zero;
  logic        sh6_alt;
  inst_class_e cls_raw;
  inst_class_e cls;
  logic        legal;
  alu_op_e     alu_op;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_u;
  word_t       imm;
  logic        rs1_rd;
  logic        rs2_rd;
  logic        rd_ena;

  assign inst   = fetch_i.inst;
  assign opc    = inst[6:2];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  // sub / arithmetic shift select
  assign alt    = inst[30];

  assign f7_zero  = funct7 == 7'b0000000;
  assign f7_alt   = funct7 == 7'b0100000;
  // RV64 immediate shifts carry a 6-bit shamt
  assign sh6_zero = inst[31:26] == 6'b000000;
  assign sh6_alt  = inst[31:26] == 6'b010000;

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {{44{inst[31]}}, inst[31:12]};

  always_comb begin
    case (opc)
      OPC_LOAD:    cls_raw = CLS_LOAD;
      OPC_STORE:   cls_raw = CLS_STORE;
      OPC_BRANCH:  cls_raw = CLS_BRANCH;
      OPC_OP:      cls_raw = CLS_REGREG;
      OPC_OP_IMM:  cls_raw = CLS_REGIMM;
      OPC_OPW:     cls_raw = CLS_REGREGW;
      OPC_OP_IMMW: cls_raw = CLS_REGIMMW;
      OPC_LUI:     cls_raw = CLS_LUI;
      OPC_AUIPC:   cls_raw = CLS_AUIPC;
      OPC_JAL:     cls_raw = CLS_JAL;
      OPC_JALR:    cls_raw = CLS_JALR;
      default:     cls_raw = CLS_NONE;
    endcase
  end

  // reserved funct fields and M extension (funct7[0]) are rejected here
  always_comb begin
    case (cls_raw)
      CLS_REGREG:  legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
      CLS_REGIMM: begin
        case (funct3)
          3'b001:  legal = sh6_zero;
          3'b101:  legal = sh6_zero || sh6_alt;
          default: legal = 1'b1;
        endcase
      end
      CLS_REGREGW: begin
        case (funct3)
          3'b000, 3'b101: legal = f7_zero || f7_alt;
          3'b001:         legal = f7_zero;
          default:        legal = 1'b0;
        endcase
      end
      CLS_REGIMMW: begin
        case (funct3)
          3'b000:  legal = 1'b1;
          3'b001:  legal = f7_zero;
          3'b101:  legal = f7_zero || f7_alt;
          default: legal = 1'b0;
        endcase
      end
      CLS_LOAD:    legal = funct3 != 3'b111;
      CLS_STORE:   legal = !funct3[2];
      CLS_BRANCH:  legal = funct3[2:1] != 2'b01;
      CLS_JALR:    legal = funct3 == 3'b000;
      default:     legal = 1'b1;
    endcase
  end

  always_comb begin
    if (fetch_i.valid && inst[1:0] == 2'b11 && legal) begin
      cls = cls_raw;
    end else begin
      cls = CLS_NONE;
    end
  end

  always_comb begin
    case (cls)
      CLS_REGREG, CLS_REGIMM: begin
        case (funct3)
          3'b000:  alu_op = (cls == CLS_REGREG && alt) ? SUB : ADD;
          3'b001:  alu_op = SLL;
          3'b010:  alu_op = SLT;
          3'b011:  alu_op = SLTU;
          3'b100:  alu_op = XOR;
          3'b101:  alu_op = alt ? SRA : SRL;
          3'b110:  alu_op = OR;
          default: alu_op = AND;
        endcase
      end
      CLS_REGREGW, CLS_REGIMMW: begin
        case (funct3)
          3'b000:  alu_op = (cls == CLS_REGREGW && alt) ? SUBW : ADDW;
          3'b001:  alu_op = SLLW;
          default: alu_op = alt ? SRAW : SRLW;
        endcase
      end
      CLS_LOAD, CLS_STORE, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR: alu_op = ADD;
      // branches carry their condition in funct3
      default: alu_op = NOP;
    endcase
  end

  always_comb begin
    case (cls)
      CLS_REGIMM, CLS_REGIMMW, CLS_LOAD, CLS_JALR: imm = imm_i;
      CLS_STORE:                                    imm = imm_s;
      CLS_LUI, CLS_AUIPC:                           imm = imm_u;
      default:                                      imm = '0;
    endcase
  end

  assign rs1_rd = !(cls inside {CLS_NONE, CLS_LUI, CLS_AUIPC, CLS_JAL});
  assign rs2_rd = cls inside {CLS_REGREG, CLS_REGREGW, CLS_BRANCH, CLS_STORE};
  assign rd_ena = (rd != '0) && (cls inside {CLS_REGREG, CLS_REGIMM, CLS_REGREGW,
                                             CLS_REGIMMW, CLS_LOAD, CLS_LUI,
                                             CLS_AUIPC, CLS_JAL, CLS_JALR});

  always_comb begin
    dec_o.cls        = cls;
    dec_o.alu_op     = alu_op;
    // the classes with a funct3 field are exactly those reading rs1
    dec_o.funct3     = rs1_rd ? funct3 : 3'b000;
    dec_o.rs1        = rs1_rd ? rs1 : 5'd0;
    dec_o.rs2        = rs2_rd ? rs2 : 5'd0;
    dec_o.rs1_rd     = rs1_rd;
    dec_o.rs2_rd     = rs2_rd;
    dec_o.rd.ena     = rd_ena;
    dec_o.rd.addr    = rd_ena ? rd : 5'd0;
    dec_o.imm        = imm;
    dec_o.mem_offset = (cls inside {CLS_LOAD, CLS_STORE}) ? imm[11:0] : 12'd0;
  end

endmodule

// ==== design/operand_select.sv ====
`timescale 1ns/1ps
// forwarding trusts wr.ena to be low for x0 writes, as the decoder guarantees
module operand_select import rv_id_pkg::*; (
  input  dec_t  dec_i,
  input  word_t pc_i,
  input  word_t rs1_data_i,
  input  word_t rs2_data_i,
  input  fwd_t  ex_fwd_i,
  input  fwd_t  mem_fwd_i,
  output word_t op1_o,
  output word_t op2_o
);

  word_t rs1_val;
  word_t rs2_val;

  // execute is youngest, so it wins over memory
  function automatic word_t resolve(reg_addr_t addr, word_t rf_data);
    if (ex_fwd_i.wr.ena && ex_fwd_i.wr.addr == addr) begin
      return ex_fwd_i.data;
    end else if (mem_fwd_i.wr.ena && mem_fwd_i.wr.addr == addr) begin
      return mem_fwd_i.data;
    end
    return rf_data;
  endfunction

  assign rs1_val = resolve(dec_i.rs1, rs1_data_i);
  assign rs2_val = resolve(dec_i.rs2, rs2_data_i);

  always_comb begin
    if (dec_i.rs1_rd) begin
      op1_o = rs1_val;
    end else if (dec_i.cls inside {CLS_AUIPC, CLS_JAL}) begin
      op1_o = pc_i;
    end else begin
      op1_o = '0;
    end
  end

  always_comb begin
    if (dec_i.rs2_rd) begin
      op2_o = rs2_val;
    end else if (dec_i.cls inside {CLS_REGIMM, CLS_REGIMMW, CLS_LUI, CLS_AUIPC}) begin
      op2_o = dec_i.imm;
    end else if (dec_i.cls inside {CLS_JAL, CLS_JALR}) begin
      // link value, execute adds 4
      op2_o = pc_i;
    end else begin
      op2_o = '0;
    end
  end

endmodule

// ==== design/hazard_ctrl.sv ====
`timescale 1ns/1ps
// redirect_pc_o is only meaningful while redirect_o is high
module hazard_ctrl import rv_id_pkg::*; (
  input  logic      valid_i,
  input  dec_t      dec_i,
  input  word_t     op1_i,
  input  rd_write_t ex_wr_i,
  input  rd_write_t mem_wr_i,
  input  rd_write_t wb_wr_i,
  input  logic      ex_is_load_i,
  output logic      stall_o,
  output logic      redirect_o,
  output word_t     redirect_pc_o
);

  logic  rs1_load_use;
  logic  rs2_load_use;
  logic  rs1_in_flight;
  word_t target;

  function automatic logic hits(rd_write_t wr, reg_addr_t addr);
    return wr.ena && wr.addr == addr;
  endfunction

  // load data arrives too late to forward from execute
  assign rs1_load_use = dec_i.rs1_rd && hits(ex_wr_i, dec_i.rs1);
  assign rs2_load_use = dec_i.rs2_rd && hits(ex_wr_i, dec_i.rs2);
  assign stall_o      = valid_i && ex_is_load_i && (rs1_load_use || rs2_load_use);

  // jalr base still being written somewhere downstream
  assign rs1_in_flight = hits(ex_wr_i, dec_i.rs1) || hits(mem_wr_i, dec_i.rs1) ||
                         hits(wb_wr_i, dec_i.rs1);
  assign redirect_o    = valid_i && dec_i.cls == CLS_JALR && rs1_in_flight;

  assign target        = op1_i + dec_i.imm;
  assign redirect_pc_o = {target[XLEN-1:1], 1'b0};

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps
// a stall replaces the whole bundle by zeros, not just valid
module id_ex_reg import rv_id_pkg::*; (
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   stall_i,
  input  id_ex_t bundle_i,
  output id_ex_t bundle_o
);

  id_ex_t bundle_d;

  // bubble while the held instruction waits for its load
  always_comb begin
    if (stall_i) begin
      bundle_d = '0;
    end else begin
      bundle_d = bundle_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bundle_o <= '0;
    end else begin
      bundle_o <= bundle_d;
    end
  end

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps
// no back-pressure from execute; fetch must hold fetch_i while stall_o is high
module id_stage import rv_id_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  fetch_t    fetch_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  fwd_t      ex_fwd_i,
  input  logic      ex_is_load_i,
  input  fwd_t      mem_fwd_i,
  input  rd_write_t wb_wr_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output logic      stall_o,
  output logic      redirect_o,
  output word_t     redirect_pc_o,
  output id_ex_t    id_ex_o
);

  dec_t   dec;
  word_t  op1;
  word_t  op2;
  logic   stall;
  id_ex_t id_ex_d;

  rv_decoder i_rv_decoder (
    .fetch_i (fetch_i),
    .dec_o   (dec)
  );

  operand_select i_operand_select (
    .dec_i      (dec),
    .pc_i       (fetch_i.pc),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .ex_fwd_i   (ex_fwd_i),
    .mem_fwd_i  (mem_fwd_i),
    .op1_o      (op1),
    .op2_o      (op2)
  );

  hazard_ctrl i_hazard_ctrl (
    .valid_i       (fetch_i.valid),
    .dec_i         (dec),
    .op1_i         (op1),
    .ex_wr_i       (ex_fwd_i.wr),
    .mem_wr_i      (mem_fwd_i.wr),
    .wb_wr_i       (wb_wr_i),
    .ex_is_load_i  (ex_is_load_i),
    .stall_o       (stall),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  // zero addresses mean no read
  assign rs1_addr_o = dec.rs1;
  assign rs2_addr_o = dec.rs2;
  assign stall_o    = stall;

  always_comb begin
    id_ex_d.valid      = fetch_i.valid;
    id_ex_d.pc         = fetch_i.pc;
    id_ex_d.cls        = dec.cls;
    id_ex_d.alu_op     = dec.alu_op;
    id_ex_d.funct3     = dec.funct3;
    id_ex_d.op1        = op1;
    id_ex_d.op2        = op2;
    id_ex_d.rd         = dec.rd;
    id_ex_d.mem_offset = dec.mem_offset;
  end

  id_ex_reg i_id_ex_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (stall),
    .bundle_i (id_ex_d),
    .bundle_o (id_ex_o)
  );

endmodule

// ==== test/id_ref_model.svh ====
// expected decode-stage results; assumes legal encodings and no enabled writes to x0
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd, logic [4:0] opc);
  return {f7, rs2, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                reg_addr_t rd, logic [4:0] opc);
  return {imm, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic inst_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
endfunction

function automatic inst_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH, 2'b11};
endfunction

function automatic inst_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [4:0] opc);
  return {imm, rd, opc, 2'b11};
endfunction

function automatic inst_t enc_j(logic [20:0] imm, reg_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
endfunction

// youngest producer first
function automatic word_t fwd_value(reg_addr_t a, word_t rf, fwd_t ex, fwd_t mem);
  if (ex.wr.ena && ex.wr.addr == a) begin
    return ex.data;
  end
  if (mem.wr.ena && mem.wr.addr == a) begin
    return mem.data;
  end
  return rf;
endfunction

function automatic void ref_model(
  input fetch_t f, input word_t rf1, input word_t rf2, input fwd_t ex, input fwd_t mem,
  input rd_write_t wb, input logic is_load, output id_ex_t exp, output reg_addr_t ra1,
  output reg_addr_t ra2, output logic stall, output logic redir, output word_t tgt);
  inst_class_e cls;
  alu_op_e     op;
  logic [2:0]  f3;
  logic        alt;
  logic        rd1;
  logic        rd2;
  word_t       imm;
  reg_addr_t   rd;
  f3  = f.inst[14:12];
  alt = f.inst[30];
  rd  = f.inst[11:7];
  cls = CLS_NONE;
  if (f.valid) begin
    case (f.inst[6:2])
      OPC_LOAD:    cls = CLS_LOAD;
      OPC_STORE:   cls = CLS_STORE;
      OPC_BRANCH:  cls = CLS_BRANCH;
      OPC_OP:      cls = CLS_REGREG;
      OPC_OP_IMM:  cls = CLS_REGIMM;
      OPC_OPW:     cls = CLS_REGREGW;
      OPC_OP_IMMW: cls = CLS_REGIMMW;
      OPC_LUI:     cls = CLS_LUI;
      OPC_AUIPC:   cls = CLS_AUIPC;
      OPC_JAL:     cls = CLS_JAL;
      OPC_JALR:    cls = CLS_JALR;
      default:     cls = CLS_NONE;
    endcase
  end
  op = ADD;
  if (cls == CLS_REGREG || cls == CLS_REGIMM) begin
    case (f3)
      3'd0:    op = (cls == CLS_REGREG && alt) ? SUB : ADD;
      3'd1:    op = SLL;
      3'd2:    op = SLT;
      3'd3:    op = SLTU;
      3'd4:    op = XOR;
      3'd5:    op = alt ? SRA : SRL;
      3'd6:    op = OR;
      default: op = AND;
    endcase
  end else if (cls == CLS_REGREGW || cls == CLS_REGIMMW) begin
    if (f3 == 3'd0) begin
      op = (cls == CLS_REGREGW && alt) ? SUBW : ADDW;
    end else begin
      op = (f3 == 3'd1) ? SLLW : (alt ? SRAW : SRLW);
    end
  end else if (cls == CLS_BRANCH || cls == CLS_NONE) begin
    op = NOP;
  end
  imm = '0;
  if (cls inside {CLS_REGIMM, CLS_REGIMMW, CLS_LOAD, CLS_JALR}) begin
    imm = word_t'($signed(f.inst[31:20]));
  end else if (cls == CLS_STORE) begin
    imm = word_t'($signed({f.inst[31:25], f.inst[11:7]}));
  end else if (cls inside {CLS_LUI, CLS_AUIPC}) begin
    imm = word_t'($signed(f.inst[31:12]));
  end
  rd1 = !(cls inside {CLS_NONE, CLS_LUI, CLS_AUIPC, CLS_JAL});
  rd2 = cls inside {CLS_REGREG, CLS_REGREGW, CLS_BRANCH, CLS_STORE};
  ra1 = rd1 ? f.inst[19:15] : 5'd0;
  ra2 = rd2 ? f.inst[24:20] : 5'd0;
  exp.valid  = f.valid;
  exp.pc     = f.pc;
  exp.cls    = cls;
  exp.alu_op = op;
  exp.funct3 = rd1 ? f3 : 3'd0;
  if (rd1) begin
    exp.op1 = fwd_value(ra1, rf1, ex, mem);
  end else begin
    exp.op1 = (cls inside {CLS_AUIPC, CLS_JAL}) ? f.pc : '0;
  end
  if (rd2) begin
    exp.op2 = fwd_value(ra2, rf2, ex, mem);
  end else if (cls inside {CLS_REGIMM, CLS_REGIMMW, CLS_LUI, CLS_AUIPC}) begin
    exp.op2 = imm;
  end else begin
    exp.op2 = (cls inside {CLS_JAL, CLS_JALR}) ? f.pc : '0;
  end
  exp.rd.ena = rd != 5'd0 && !(cls inside {CLS_NONE, CLS_STORE, CLS_BRANCH});
  exp.rd.addr   = exp.rd.ena ? rd : 5'd0;
  exp.mem_offset = (cls inside {CLS_LOAD, CLS_STORE}) ? imm[11:0] : 12'd0;
  stall = f.valid && is_load && ex.wr.ena &&
          ((rd1 && ex.wr.addr == ra1) || (rd2 && ex.wr.addr == ra2));
  redir = f.valid && cls == CLS_JALR &&
          ((ex.wr.ena && ex.wr.addr == ra1) || (mem.wr.ena && mem.wr.addr == ra1) ||
           (wb.ena && wb.addr == ra1));
  tgt = (exp.op1 + imm) & ~64'd1;
  // a stalled instruction leaves a bubble behind
  if (stall) begin
    exp = '0;
  end
endfunction

`endif

// ==== test/tb_id_stage.sv ====
`timescale 1ns/1ps
// directed and seeded random checks; bundles are compared one cycle after their stimulus
module tb_id_stage import rv_id_pkg::*; ();

  `include "id_ref_model.svh"

  logic      clk;
  logic      arst_n;
  fetch_t    fetch;
  word_t     rs1_data;
  word_t     rs2_data;
  fwd_t      ex_fwd;
  logic      ex_is_load;
  fwd_t      mem_fwd;
  rd_write_t wb_wr;
  reg_addr_t rs1_addr_o;
  reg_addr_t rs2_addr_o;
  logic      stall_o;
  logic      redirect_o;
  word_t     redirect_pc_o;
  id_ex_t    id_ex_o;

  id_ex_t    exp_q[$];
  id_ex_t    exp_cur;
  int        errors;
  int        checks;

  id_stage i_id_stage (
    .clk_i (clk), .arst_n_i (arst_n), .fetch_i (fetch), .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data), .ex_fwd_i (ex_fwd), .ex_is_load_i (ex_is_load),
    .mem_fwd_i (mem_fwd), .wb_wr_i (wb_wr), .rs1_addr_o (rs1_addr_o),
    .rs2_addr_o (rs2_addr_o), .stall_o (stall_o), .redirect_o (redirect_o),
    .redirect_pc_o (redirect_pc_o), .id_ex_o (id_ex_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #20000;
    $display("timeout: simulation did not finish");
    $display("Done: errors found");
    $finish;
  end

  task automatic check_bundle(string name, id_ex_t got, id_ex_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  // bundle checker, samples just after the edge
  initial begin
    forever begin
      @(posedge clk);
      #0.5;
      if (exp_q.size() > 0) begin
        exp_cur = exp_q.pop_front();
        check_bundle("id_ex_o", id_ex_o, exp_cur);
      end
    end
  end

  function automatic logic [31:0] rnd();
    return $urandom();
  endfunction

  function automatic reg_addr_t rnd_reg();
    return reg_addr_t'(rnd() % 31 + 1);
  endfunction

  function automatic fwd_t make_fwd(logic ena, reg_addr_t addr);
    fwd_t w;
    w.wr.ena  = ena;
    w.wr.addr = addr;
    w.data    = {rnd(), rnd()};
    return w;
  endfunction

  task automatic apply(inst_t inst, fwd_t ex, fwd_t mem, rd_write_t wb, logic ld);
    fetch_t    f;
    id_ex_t    e;
    reg_addr_t a1;
    reg_addr_t a2;
    logic      st;
    logic      rdr;
    word_t     t;
    @(posedge clk);
    #1;
    f.valid = 1'b1;
    f.pc    = {rnd(), rnd()} & ~64'd3;
    f.inst  = inst;
    fetch      = f;
    rs1_data   = {rnd(), rnd()};
    rs2_data   = {rnd(), rnd()};
    ex_fwd     = ex;
    mem_fwd    = mem;
    wb_wr      = wb;
    ex_is_load = ld;
    ref_model(f, rs1_data, rs2_data, ex, mem, wb, ld, e, a1, a2, st, rdr, t);
    #2;
    check_addr("rs1_addr_o", rs1_addr_o, a1);
    check_addr("rs2_addr_o", rs2_addr_o, a2);
    check_bit("stall_o", stall_o, st);
    check_bit("redirect_o", redirect_o, rdr);
    if (rdr) begin
      check_word("redirect_pc_o", redirect_pc_o, t);
    end
    exp_q.push_back(e);
  endtask

  task automatic end_test(string name, int err_before);
    @(posedge clk);
    #1;
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  initial begin
    int          n;
    int          e0;
    int          kind;
    logic [2:0]  f3;
    logic [11:0] imm;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    inst_t       inst;
    fwd_t        none;
    rd_write_t   no_wb;
    void'($urandom(32'hf18f));
    errors     = 0;
    checks     = 0;
    none       = '0;
    no_wb      = '0;
    // a valid jalr during reset, which the register must not take
    fetch.valid = 1'b1;
    fetch.pc    = 64'h1000;
    fetch.inst  = enc_i(12'h010, 5'd7, 3'd0, 5'd1, OPC_JALR);
    rs1_data   = '0;
    rs2_data   = '0;
    ex_fwd     = '0;
    mem_fwd    = '0;
    wb_wr      = '0;
    ex_is_load = 1'b0;
    arst_n     = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    e0 = errors;
    // invalid fetch hides a load-use match and a jalr base hit
    fetch.valid    = 1'b0;
    ex_fwd.wr.ena  = 1'b1;
    ex_fwd.wr.addr = 5'd7;
    ex_is_load     = 1'b1;
    #1;
    check_bundle("id_ex_o", id_ex_o, '0);
    check_bit("stall_o", stall_o, 1'b0);
    check_bit("redirect_o", redirect_o, 1'b0);
    end_test("reset", e0);

    e0 = errors;
    for (int i = 0; i < 40; i++) begin
      kind = int'(rnd() % 4);
      f3   = 3'(rnd());
      imm  = 12'(rnd());
      rd   = 5'(rnd());
      rs1  = 5'(rnd());
      rs2  = 5'(rnd());
      if (kind >= 2 && !(f3 inside {3'd0, 3'd1, 3'd5})) begin
        f3 = 3'd0;
      end
      if (f3 == 3'd1) begin
        imm[11:5] = 7'd0;
      end else if (f3 == 3'd5) begin
        imm[11:5] = rnd() % 2 == 0 ? 7'h20 : 7'h00;
      end
      case (kind)
        0: inst = enc_r(((f3 == 3'd0 || f3 == 3'd5) && rnd() % 2 == 0) ? 7'h20 : 7'h00,
                        rs2, rs1, f3, rd, OPC_OP);
        1: inst = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
        2: inst = enc_r((f3 != 3'd1 && rnd() % 2 == 0) ? 7'h20 : 7'h00,
                        rs2, rs1, f3, rd, OPC_OPW);
        default: inst = enc_i(imm, rs1, f3, rd, OPC_OP_IMMW);
      endcase
      apply(inst, none, none, no_wb, 1'b0);
    end
    end_test("alu decode", e0);

    e0 = errors;
    for (int ex_t = 0; ex_t < 3; ex_t++) begin
      for (int mem_t = 0; mem_t < 3; mem_t++) begin
        rs1  = rnd_reg();
        rs2  = 5'(rs1 % 31 + 1);
        inst = enc_r(7'h00, rs2, rs1, 3'd0, rnd_reg(), OPC_OP);
        apply(inst, make_fwd(ex_t != 0, ex_t == 1 ? rs1 : rs2),
              make_fwd(mem_t != 0, mem_t == 1 ? rs1 : rs2), no_wb, 1'b0);
      end
    end
    end_test("forwarding", e0);

    e0 = errors;
    for (int i = 0; i < 24; i++) begin
      // each class gets rd zero in some rounds and nonzero in others
      rd  = ((i / 6) % 2 == 0) ? 5'd0 : rnd_reg();
      rs1 = rnd_reg();
      rs2 = rnd_reg();
      f3  = 3'(rnd());
      case (i % 6)
        0: inst = enc_i(12'(rnd()), rs1, f3 == 3'd7 ? 3'd3 : f3, rd, OPC_LOAD);
        1: inst = enc_s(12'(rnd()), rs2, rs1, {1'b0, f3[1:0]});
        2: inst = enc_b(13'(rnd()), rs2, rs1, f3[2:1] == 2'b01 ? 3'd0 : f3);
        3: inst = enc_u(20'(rnd()), rd, OPC_LUI);
        4: inst = enc_u(20'(rnd()), rd, OPC_AUIPC);
        default: inst = enc_j(21'(rnd()), rd);
      endcase
      apply(inst, none, none, no_wb, 1'b0);
    end
    end_test("other classes", e0);

    e0 = errors;
    inst = enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd9, OPC_OP);
    apply(inst, make_fwd(1'b1, 5'd5), none, no_wb, 1'b1);
    apply(inst, none, none, no_wb, 1'b1);
    apply(inst, make_fwd(1'b1, 5'd6), none, no_wb, 1'b1);
    apply(inst, make_fwd(1'b1, 5'd12), none, no_wb, 1'b1);
    end_test("load-use stall", e0);

    e0 = errors;
    for (int src = 0; src < 4; src++) begin
      inst = enc_i(12'(rnd()), 5'd7, 3'd0, rnd_reg(), OPC_JALR);
      apply(inst, make_fwd(src == 1, 5'd7), make_fwd(src == 2, 5'd7),
            '{ena: src == 3, addr: 5'd7}, 1'b0);
    end
    end_test("jalr redirect", e0);

    n = 0;
    while (exp_q.size() > 0 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("expected bundles were never compared");
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== id_stage.f ====
+incdir+test
design/rv_id_pkg.sv
design/rv_decoder.sv
design/operand_select.sv
design/hazard_ctrl.sv
design/id_ex_reg.sv
design/id_stage.sv
test/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs tb_id_stage with Verilator; exits nonzero on failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_id_stage -f id_stage.f -o sim_id_stage \
  > build.log 2>&1 \
  && ./obj_dir/sim_id_stage > sim.log 2>&1 \
  || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "Done: errors found" sim.log \
  && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
